// File: rtl/mf_pkg.sv
package mf_pkg;

    // stream geometry
    localparam int SAMP_BITS = 12;
    localparam int NSAMP     = 8;
    localparam int NTAPS     = 8;

    // samples kept from the previous beat, and the full window seen by the lanes
    localparam int HIST_LEN = NTAPS - 1;
    localparam int WIN_LEN  = NSAMP + NTAPS - 1;

    // coefficient and arithmetic widths
    localparam int COEF_BITS  = 4;
    localparam int PROD_BITS  = SAMP_BITS + COEF_BITS;
    localparam int NPAIR      = NTAPS / 2;
    localparam int ACC_BITS   = 18;
    localparam int OUT_SHIFT  = 4;
    localparam int SHIFT_BITS = ACC_BITS - OUT_SHIFT;
    localparam int RND_CONST  = 1 << (OUT_SHIFT - 1);

    // input beat to output beat, in clocks
    localparam int MF_LATENCY = 3;

    typedef logic signed [COEF_BITS-1:0] coef_t;
    typedef logic signed [SAMP_BITS-1:0] sample_t;
    typedef logic signed [ACC_BITS-1:0]  acc_t;

    // element 0 is the oldest sample of the beat
    typedef sample_t [NSAMP-1:0] beat_t;

    // tap 0 first; tap 0 multiplies the newest sample
    localparam coef_t MF_COEFF [NTAPS] = '{
        -4'sd1, 4'sd3, 4'sd7, 4'sd5, -4'sd2, -4'sd6, -4'sd4, 4'sd2
    };

    // full-scale limits of the output sample
    localparam sample_t SAMP_MAX = {1'b0, {(SAMP_BITS-1){1'b1}}};
    localparam sample_t SAMP_MIN = {1'b1, {(SAMP_BITS-1){1'b0}}};

    typedef enum logic {
        SUM_NORMAL,
        SUM_SATURATED
    } lane_mode_e;

endpackage

// File: rtl/sample_history.sv
module sample_history
    import mf_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  beat_t                     dat_i,
    output sample_t [WIN_LEN-1:0]     window_o
);

    // newest HIST_LEN samples of the last beat
    sample_t [HIST_LEN-1:0] hist_q;

    // reloads every clock, the stream never stalls
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
        end else begin
            hist_q <= dat_i[NSAMP-1 -: HIST_LEN];
        end
    end

    // one contiguous stretch of the sequence, oldest at index 0
    // indices 0..6 come from the register, 7..14 are the live beat
    assign window_o = {dat_i, hist_q};

endmodule

// File: rtl/mf_lane.sv
module mf_lane
    import mf_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  sample_t [NTAPS-1:0]   win_i,
    output acc_t                  sum_o
);

    // per-tap products, full precision
    logic signed [PROD_BITS-1:0] prod [NTAPS];

    // pair sums ahead of the first register
    acc_t pair_d [NPAIR];

    // stage one and stage two registers
    acc_t pair_q [NPAIR];
    acc_t sum_q;

    // tap k meets window element NTAPS-1-k, so tap 0 takes the newest sample
    always_comb begin
        for (int k = 0; k < NTAPS; k++) begin
            prod[k] = win_i[NTAPS-1-k] * MF_COEFF[k];
        end
    end

    // neighbouring taps summed, sign extended into the lane width
    always_comb begin
        for (int p = 0; p < NPAIR; p++) begin
            pair_d[p] = acc_t'(prod[2*p]) + acc_t'(prod[2*p+1]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int p = 0; p < NPAIR; p++) begin
                pair_q[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NPAIR; p++) begin
                pair_q[p] <= pair_d[p];
            end
        end
    end

    // final sum as a small adder tree
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_q <= '0;
        end else begin
            sum_q <= (pair_q[0] + pair_q[1]) + (pair_q[2] + pair_q[3]);
        end
    end

    assign sum_o = sum_q;

endmodule

// File: rtl/round_saturate.sv
module round_saturate
    import mf_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  acc_t [NSAMP-1:0]   acc_i,
    output beat_t              dat_o
);

    // sum plus half an output LSB
    acc_t rnd [NSAMP];

    // rounded sum after the downshift, still wider than a sample
    logic signed [SHIFT_BITS-1:0] shf [NSAMP];

    lane_mode_e mode [NSAMP];
    beat_t      res_d;
    beat_t      dat_q;

    always_comb begin
        for (int n = 0; n < NSAMP; n++) begin
            rnd[n] = acc_i[n] + acc_t'(RND_CONST);
            shf[n] = rnd[n][ACC_BITS-1:OUT_SHIFT];

            // exact tie: fraction was one half, round to even
            if (rnd[n][OUT_SHIFT-1:0] == '0) begin
                shf[n][0] = 1'b0;
            end

            if (shf[n] > SAMP_MAX || shf[n] < SAMP_MIN) begin
                mode[n] = SUM_SATURATED;
            end else begin
                mode[n] = SUM_NORMAL;
            end

            case (mode[n])
                // clamp toward the sign of the sum
                SUM_SATURATED: res_d[n] = shf[n][SHIFT_BITS-1] ? SAMP_MIN : SAMP_MAX;
                default:       res_d[n] = shf[n][SAMP_BITS-1:0];
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dat_q <= '0;
        end else begin
            dat_q <= res_d;
        end
    end

    assign dat_o = dat_q;

endmodule

// File: rtl/matched_filter.sv
module matched_filter
    import mf_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  beat_t   dat_i,
    output beat_t   dat_o
);

    // previous-beat tail followed by the live beat
    sample_t [WIN_LEN-1:0] window;

    // one registered sum per output sample
    acc_t [NSAMP-1:0] lane_sum;

    sample_history u_history (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .dat_i    (dat_i),
        .window_o (window)
    );

    // lane j covers window elements j .. j+NTAPS-1
    // its newest sample is dat_i[j]
    for (genvar j = 0; j < NSAMP; j++) begin : g_lane
        mf_lane u_lane (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .win_i (window[j +: NTAPS]),
            .sum_o (lane_sum[j])
        );
    end

    round_saturate u_round (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .acc_i (lane_sum),
        .dat_o (dat_o)
    );

endmodule

// File: verification/mf_check.svh
`ifndef MF_CHECK_SVH
`define MF_CHECK_SVH

// 12-bit signed output range
localparam int OUT_MAX = (1 << (SAMP_BITS - 1)) - 1;
localparam int OUT_MIN = -(1 << (SAMP_BITS - 1));

// tail of the previous beat as the model sees it, oldest first
int hist_m [HIST_LEN];

// expected beats, their saturation flags and the cycle each one is due
beat_t            exp_q [$];
logic [NSAMP-1:0] sat_q [$];
int               due_q [$];

logic [31:0] rng_state = 32'd44;

int pass_cnt = 0;
int fail_cnt = 0;

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// divide by 16, ties go to the even result
function automatic int round_half_even(input int sum);
    int r;
    int q;
    r = sum + (1 << (OUT_SHIFT - 1));
    q = r >>> OUT_SHIFT;
    if ((r & ((1 << OUT_SHIFT) - 1)) == 0) begin
        q = q & ~1;
    end
    return q;
endfunction

// history is all zeros after reset
function automatic void model_clear();
    for (int i = 0; i < HIST_LEN; i++) begin
        hist_m[i] = 0;
    end
    exp_q.delete();
    sat_q.delete();
    due_q.delete();
endfunction

// expected output beat for one input beat, then advance the history
function automatic void model_beat(input beat_t b, output beat_t exp_b,
                                   output logic [NSAMP-1:0] sat);
    int win [WIN_LEN];
    int sum;
    int q;
    for (int i = 0; i < HIST_LEN; i++) begin
        win[i] = hist_m[i];
    end
    for (int i = 0; i < NSAMP; i++) begin
        win[HIST_LEN + i] = int'(b[i]);
    end
    for (int j = 0; j < NSAMP; j++) begin
        sum = 0;
        // output j has its newest sample at window index j+7
        for (int k = 0; k < NTAPS; k++) begin
            sum += int'(MF_COEFF[k]) * win[j + NTAPS - 1 - k];
        end
        q = round_half_even(sum);
        sat[j] = (q > OUT_MAX) || (q < OUT_MIN);
        if (q > OUT_MAX) begin
            q = OUT_MAX;
        end else if (q < OUT_MIN) begin
            q = OUT_MIN;
        end
        exp_b[j] = sample_t'(q);
    end
    for (int i = 0; i < HIST_LEN; i++) begin
        hist_m[i] = win[NSAMP + i];
    end
endfunction

task automatic check_sample(input int lane, input sample_t exp_s, input sample_t act_s,
                            input lane_mode_e mode);
    if (act_s !== exp_s) begin
        $display("FAIL %0t: lane %0d expected %0d got %0d, class %s",
                 $time, lane, exp_s, act_s, mode.name());
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic check_beat(input beat_t exp_b, input beat_t act_b,
                          input logic [NSAMP-1:0] sat);
    lane_mode_e mode;
    for (int n = 0; n < NSAMP; n++) begin
        mode = sat[n] ? SUM_SATURATED : SUM_NORMAL;
        check_sample(n, exp_b[n], act_b[n], mode);
    end
endtask

// compare the oldest expected beat once its latency has passed
task automatic check_due();
    if (due_q.size() > 0 && due_q[0] == cyc) begin
        void'(due_q.pop_front());
        check_beat(exp_q.pop_front(), dat_o, sat_q.pop_front());
    end
endtask

`endif

// File: verification/mf_tb.sv
module mf_tb
    import mf_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int RST_CYCLES = 4;

    // beats per test, used to size the watchdog
    localparam int N_ZERO    = 16;
    localparam int N_IMPULSE = 2 * 3;
    localparam int N_ROUND   = 8 * 3;
    localparam int N_SAT     = 2 * 3;
    localparam int N_STREAM  = 200;
    localparam int N_DRAINS  = 13;
    localparam int MARGIN    = 40;
    localparam int N_CYCLES  = RST_CYCLES + N_ZERO + N_IMPULSE + N_ROUND + N_SAT + N_STREAM
                               + N_DRAINS * (MF_LATENCY + 3) + MARGIN;
    localparam int WATCHDOG_TIME = N_CYCLES * CLK_PERIOD;

    logic  clk_i;
    logic  rst_i;
    beat_t dat_i;
    beat_t dat_o;

    // rising edges seen so far
    int cyc = 0;

    matched_filter dut_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .dat_i (dat_i),
        .dat_o (dat_o)
    );

    `include "mf_check.svh"

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    function automatic beat_t fill_beat(input int x);
        beat_t b;
        for (int i = 0; i < NSAMP; i++) begin
            b[i] = sample_t'(x);
        end
        return b;
    endfunction

    task automatic apply_reset();
        rst_i = 1'b1;
        dat_i = '0;
        model_clear();
        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;
    endtask

    // one beat per clock with checks at the falling edge and drives just after the rising one
    task automatic drive_beat(input beat_t b);
        beat_t            exp_b;
        logic [NSAMP-1:0] sat;
        @(negedge clk_i);
        check_due();
        @(posedge clk_i);
        #DRIVE_DLY;
        dat_i = b;
        model_beat(b, exp_b, sat);
        exp_q.push_back(exp_b);
        sat_q.push_back(sat);
        due_q.push_back(cyc + MF_LATENCY);
    endtask

    // holding the last beat keeps the history consistent with the model
    task automatic drain_pipeline();
        while (due_q.size() > 0) begin
            @(negedge clk_i);
            check_due();
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%s: done, %0d failing checks", name, fail_cnt - fails_before);
    endtask

    task automatic reset_state_test();
        int fails_before;
        fails_before = fail_cnt;
        check_beat('0, dat_o, '0);
        repeat (N_ZERO) drive_beat('0);
        drain_pipeline();
        report_test("reset_state", fails_before);
    endtask

    // each output reads a coefficient times 16 across the beat boundary
    task automatic impulse_test();
        int    fails_before;
        int    pos [2] = '{0, 5};
        beat_t b;
        fails_before = fail_cnt;
        for (int p = 0; p < 2; p++) begin
            b = '0;
            b[pos[p]] = sample_t'(256);
            drive_beat(b);
            drive_beat('0);
            drive_beat('0);
        end
        drain_pipeline();
        report_test("impulse_response", fails_before);
    endtask

    // the coefficients sum to 4 so a constant x gives lane sums of 4x
    task automatic rounding_test();
        int fails_before;
        int vals [8] = '{2, 6, 10, -2, -6, -10, 1, 3};
        int want [8] = '{0, 2, 2, 0, -2, -2, 0, 1};
        fails_before = fail_cnt;
        for (int v = 0; v < 8; v++) begin
            repeat (3) drive_beat(fill_beat(vals[v]));
            drain_pipeline();
            // in steady state every lane sees only x
            for (int n = 0; n < NSAMP; n++) begin
                check_sample(n, sample_t'(want[v]), dat_o[n], SUM_NORMAL);
            end
        end
        report_test("rounding", fails_before);
    endtask

    // samples follow the coefficient signs so the newest lane sums at full scale
    task automatic saturation_test();
        int    fails_before;
        beat_t b;
        fails_before = fail_cnt;
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < NSAMP; i++) begin
                if (MF_COEFF[NTAPS-1-i] >= 0) begin
                    b[i] = (s == 0) ? sample_t'(OUT_MAX) : sample_t'(OUT_MIN);
                end else begin
                    b[i] = (s == 0) ? sample_t'(-OUT_MAX) : sample_t'(OUT_MAX);
                end
            end
            repeat (3) drive_beat(b);
            drain_pipeline();
            check_sample(NSAMP - 1, (s == 0) ? sample_t'(OUT_MAX) : sample_t'(OUT_MIN),
                         dat_o[NSAMP-1], SUM_SATURATED);
        end
        report_test("saturation", fails_before);
    endtask

    task automatic streaming_test();
        int          fails_before;
        beat_t       b;
        logic [31:0] r;
        fails_before = fail_cnt;
        for (int i = 0; i < N_STREAM; i++) begin
            for (int n = 0; n < NSAMP; n++) begin
                r = next_random();
                b[n] = sample_t'(r[SAMP_BITS-1:0]);
            end
            drive_beat(b);
        end
        drain_pipeline();
        report_test("streaming", fails_before);
    endtask

    initial begin
        #WATCHDOG_TIME;
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        dat_i = '0;
        apply_reset();
        reset_state_test();
        impulse_test();
        rounding_test();
        saturation_test();
        streaming_test();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verification
rtl/mf_pkg.sv
rtl/sample_history.sv
rtl/mf_lane.sv
rtl/round_saturate.sv
rtl/matched_filter.sv
verification/mf_tb.sv

// File: Makefile
# Verilator build and run for the matched filter testbench

VERILATOR ?= verilator
TOP       ?= mf_tb
FILE_LIST ?= tb.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS)
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

# build, run, and fail unless the pass message appears on a line of its own
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
